//--- verilog/mmu_pkg.sv
// Address layout and table sizes for the address translation unit
// Pages are 16 KByte and each TLB entry and table entry covers a page pair
// The page table holds only 64 pairs, so only address bits 22:17 are mapped
package mmu_pkg;

	// Virtual address fields
	localparam int VADDR_BITS = 32;
	localparam int PAGE_BITS = 14;
	localparam int SET_LSB = 15;
	localparam int SET_BITS = 2;
	localparam int TAG_LSB = 17;
	localparam int TAG_BITS = 15;

	// TLB geometry
	localparam int SETS = 1 << SET_BITS;
	localparam int WAYS = 4;
	localparam int WAY_BITS = 2;
	localparam int AGE_BITS = 2;
	// Fresh entries and hits get the top age
	localparam logic [AGE_BITS-1:0] AGE_MAX = 2'd3;
	localparam int LRU_TIMER_N = 10;

	// Translation payload, pairs hold the even page in the low half
	localparam int PPN_BITS = 18;
	localparam int FLAG_BITS = 14;
	localparam int FLAG_PRESENT = 0;
	localparam int PPN_PAIR_BITS = 2 * PPN_BITS;
	localparam int FLAG_PAIR_BITS = 2 * FLAG_BITS;

	// Page table
	localparam int PT_INDEX_BITS = 6;
	localparam int PT_DEPTH = 1 << PT_INDEX_BITS;
	// Address bits from here up must be zero
	localparam int PT_LIMIT_LSB = TAG_LSB + PT_INDEX_BITS;

	// Miss sequencer
	typedef enum logic [1:0] {
		WALK_IDLE,
		WALK_READ,
		WALK_FILL,
		WALK_RETRY
	} walk_state_t;

endpackage

//--- verilog/mmu_request_port.sv
// One request in flight; a req while busy is dropped, not queued
// The captured address stays stable until done
`timescale 1ns/1ns

module mmu_request_port (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic req,
	input  logic [mmu_pkg::VADDR_BITS-1:0] req_vaddr,
	input  logic retry,
	input  logic done,
	output logic busy,
	output logic lookup,
	output logic [mmu_pkg::VADDR_BITS-1:0] lookup_vaddr
);

	logic accept;

	// New request only when idle
	assign accept = req && !busy;

	// Busy and lookup strobe
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			busy <= 1'b0;
			lookup <= 1'b0;
		end else begin
			if (accept) begin
				busy <= 1'b1;
			end else if (done) begin
				// Result delivered
				busy <= 1'b0;
			end
			// First lookup one cycle after accept, again after a walk
			lookup <= accept || retry;
		end
	end

	// Held address, also used by walker and response
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			lookup_vaddr <= req_vaddr;
		end
	end

endmodule

//--- verilog/mmu_tlb.sv
// 4 sets of 4 ways, each way maps a pair of neighbouring pages
// Ages count down on aging timer wrap; victim is the lowest age
// No coherence with the page table, software must flush after table edits
`timescale 1ns/1ns

module mmu_tlb (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic flush,
	input  logic lookup,
	input  logic [mmu_pkg::VADDR_BITS-1:0] lookup_vaddr,
	input  logic fill,
	input  logic [mmu_pkg::VADDR_BITS-1:0] fill_vaddr,
	input  logic [mmu_pkg::PPN_PAIR_BITS-1:0] fill_ppn,
	input  logic [mmu_pkg::FLAG_PAIR_BITS-1:0] fill_flags,
	output logic rd_valid,
	output logic rd_hit,
	output logic [mmu_pkg::PPN_PAIR_BITS-1:0] rd_ppn,
	output logic [mmu_pkg::FLAG_PAIR_BITS-1:0] rd_flags
);

	// Age 0 marks an invalid way
	logic [mmu_pkg::AGE_BITS-1:0] age_q [mmu_pkg::SETS][mmu_pkg::WAYS];
	logic [mmu_pkg::TAG_BITS-1:0] tag_q [mmu_pkg::SETS][mmu_pkg::WAYS];
	logic [mmu_pkg::PPN_PAIR_BITS-1:0] ppn_q [mmu_pkg::SETS][mmu_pkg::WAYS];
	logic [mmu_pkg::FLAG_PAIR_BITS-1:0] flags_q [mmu_pkg::SETS][mmu_pkg::WAYS];

	logic [mmu_pkg::SET_BITS-1:0] look_set;
	logic [mmu_pkg::TAG_BITS-1:0] look_tag;
	logic look_hit;
	logic [mmu_pkg::WAY_BITS-1:0] look_way;
	logic [mmu_pkg::SET_BITS-1:0] fill_set;
	logic [mmu_pkg::WAY_BITS-1:0] victim_way;
	logic [mmu_pkg::AGE_BITS-1:0] victim_age;
	logic [mmu_pkg::LRU_TIMER_N-1:0] lru_timer;
	logic age_tick;

	// Field split, bit 14 only matters downstream
	assign look_set = lookup_vaddr[mmu_pkg::SET_LSB +: mmu_pkg::SET_BITS];
	assign look_tag = lookup_vaddr[mmu_pkg::TAG_LSB +: mmu_pkg::TAG_BITS];
	assign fill_set = fill_vaddr[mmu_pkg::SET_LSB +: mmu_pkg::SET_BITS];

	// Tag compare across the set, lowest way wins
	always_comb begin
		look_hit = 1'b0;
		look_way = '0;
		for (int w = mmu_pkg::WAYS - 1; w >= 0; w--) begin
			if (age_q[look_set][w] != '0 && tag_q[look_set][w] == look_tag) begin
				look_hit = 1'b1;
				look_way = w[mmu_pkg::WAY_BITS-1:0];
			end
		end
	end

	// Victim search, strict compare keeps the lowest index on ties
	// Invalid ways have age 0 so they are taken first
	always_comb begin
		victim_way = '0;
		victim_age = age_q[fill_set][0];
		for (int w = 1; w < mmu_pkg::WAYS; w++) begin
			if (age_q[fill_set][w] < victim_age) begin
				victim_age = age_q[fill_set][w];
				victim_way = w[mmu_pkg::WAY_BITS-1:0];
			end
		end
	end

	// Free-running aging timer
	assign age_tick = &lru_timer;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lru_timer <= '0;
		end else if (flush) begin
			lru_timer <= '0;
		end else begin
			lru_timer <= lru_timer + 1'b1;
		end
	end

	// Ages: flush beats fill, a hit refreshes, the timer wrap ages the rest
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int s = 0; s < mmu_pkg::SETS; s++) begin
				for (int w = 0; w < mmu_pkg::WAYS; w++) begin
					age_q[s][w] <= '0;
				end
			end
		end else if (flush) begin
			for (int s = 0; s < mmu_pkg::SETS; s++) begin
				for (int w = 0; w < mmu_pkg::WAYS; w++) begin
					age_q[s][w] <= '0;
				end
			end
		end else begin
			for (int s = 0; s < mmu_pkg::SETS; s++) begin
				for (int w = 0; w < mmu_pkg::WAYS; w++) begin
					if (lookup && look_hit && int'(look_set) == s && int'(look_way) == w) begin
						age_q[s][w] <= mmu_pkg::AGE_MAX;
					end else if (fill && int'(fill_set) == s && int'(victim_way) == w) begin
						age_q[s][w] <= mmu_pkg::AGE_MAX;
					end else if (age_tick && age_q[s][w] > 2'd1) begin
						// Never ages down to invalid
						age_q[s][w] <= age_q[s][w] - 1'b1;
					end
				end
			end
		end
	end

	// Entry payload, validity lives in age_q
	always_ff @(posedge iCLOCK) begin
		if (fill) begin
			tag_q[fill_set][victim_way] <= fill_vaddr[mmu_pkg::TAG_LSB +: mmu_pkg::TAG_BITS];
			ppn_q[fill_set][victim_way] <= fill_ppn;
			flags_q[fill_set][victim_way] <= fill_flags;
		end
	end

	// Registered lookup result
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rd_valid <= 1'b0;
			rd_hit <= 1'b0;
		end else begin
			rd_valid <= lookup;
			// A flush in the lookup cycle forces a walk
			rd_hit <= lookup && look_hit && !flush;
		end
	end

	// Payload read, meaningful only with rd_hit
	always_ff @(posedge iCLOCK) begin
		if (lookup) begin
			rd_ppn <= ppn_q[look_set][look_way];
			rd_flags <= flags_q[look_set][look_way];
		end
	end

endmodule

//--- verilog/mmu_page_walker.sv
// Single-level table of 64 page pairs, loaded by software through pt_wr
// Faults on address bits 31:23 set or on a clear present bit
// Table writes are not snooped by the TLB
`timescale 1ns/1ns

module mmu_page_walker (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic rd_valid,
	input  logic rd_hit,
	input  logic [mmu_pkg::VADDR_BITS-1:0] lookup_vaddr,
	input  logic pt_wr,
	input  logic [mmu_pkg::PT_INDEX_BITS-1:0] pt_wr_index,
	input  logic [mmu_pkg::PPN_PAIR_BITS-1:0] pt_wr_ppn,
	input  logic [mmu_pkg::FLAG_PAIR_BITS-1:0] pt_wr_flags,
	output logic fill,
	output logic [mmu_pkg::VADDR_BITS-1:0] fill_vaddr,
	output logic [mmu_pkg::PPN_PAIR_BITS-1:0] fill_ppn,
	output logic [mmu_pkg::FLAG_PAIR_BITS-1:0] fill_flags,
	output logic retry,
	output logic walk_fault
);

	// Table RAM
	logic [mmu_pkg::PPN_PAIR_BITS-1:0] pt_ppn [mmu_pkg::PT_DEPTH];
	logic [mmu_pkg::FLAG_PAIR_BITS-1:0] pt_flags [mmu_pkg::PT_DEPTH];

	mmu_pkg::walk_state_t state;
	logic [mmu_pkg::PT_INDEX_BITS-1:0] walk_index;
	logic [mmu_pkg::FLAG_BITS-1:0] page_flags;
	logic out_of_range;
	logic entry_ok;

	// Walk address held in fill_vaddr for the whole walk
	assign walk_index = fill_vaddr[mmu_pkg::TAG_LSB +: mmu_pkg::PT_INDEX_BITS];
	assign out_of_range = |fill_vaddr[mmu_pkg::VADDR_BITS-1:mmu_pkg::PT_LIMIT_LSB];

	// Flags of the page picked by bit 14
	assign page_flags = fill_vaddr[mmu_pkg::PAGE_BITS]
		? fill_flags[mmu_pkg::FLAG_BITS +: mmu_pkg::FLAG_BITS]
		: fill_flags[0 +: mmu_pkg::FLAG_BITS];
	assign entry_ok = !out_of_range && page_flags[mmu_pkg::FLAG_PRESENT];

	// Software load port
	always_ff @(posedge iCLOCK) begin
		if (pt_wr) begin
			pt_ppn[pt_wr_index] <= pt_wr_ppn;
			pt_flags[pt_wr_index] <= pt_wr_flags;
		end
	end

	// Capture miss address, then read the entry
	always_ff @(posedge iCLOCK) begin
		if (state == mmu_pkg::WALK_IDLE && rd_valid && !rd_hit) begin
			fill_vaddr <= lookup_vaddr;
		end
		if (state == mmu_pkg::WALK_READ) begin
			fill_ppn <= pt_ppn[walk_index];
			fill_flags <= pt_flags[walk_index];
		end
	end

	// Miss sequencer
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= mmu_pkg::WALK_IDLE;
		end else begin
			case (state)
				mmu_pkg::WALK_IDLE: begin
					if (rd_valid && !rd_hit) begin
						state <= mmu_pkg::WALK_READ;
					end
				end
				mmu_pkg::WALK_READ: begin
					state <= mmu_pkg::WALK_FILL;
				end
				mmu_pkg::WALK_FILL: begin
					// Fault ends the walk here
					state <= entry_ok ? mmu_pkg::WALK_RETRY : mmu_pkg::WALK_IDLE;
				end
				default: begin
					state <= mmu_pkg::WALK_IDLE;
				end
			endcase
		end
	end

	// One-cycle strobes out of the state
	assign fill = state == mmu_pkg::WALK_FILL && entry_ok;
	assign walk_fault = state == mmu_pkg::WALK_FILL && !entry_ok;
	assign retry = state == mmu_pkg::WALK_RETRY;

endmodule

//--- verilog/mmu_response.sv
// Result register; paddr, flags, hit and fault are zero outside done
// hit means the first lookup hit, a walked request reports hit low
`timescale 1ns/1ns

module mmu_response (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic [mmu_pkg::VADDR_BITS-1:0] lookup_vaddr,
	input  logic rd_valid,
	input  logic rd_hit,
	input  logic [mmu_pkg::PPN_PAIR_BITS-1:0] rd_ppn,
	input  logic [mmu_pkg::FLAG_PAIR_BITS-1:0] rd_flags,
	input  logic walk_fault,
	input  logic retry,
	output logic done,
	output logic [mmu_pkg::VADDR_BITS-1:0] paddr,
	output logic [mmu_pkg::FLAG_BITS-1:0] flags,
	output logic hit,
	output logic fault
);

	logic walked;
	logic take_hit;
	logic done_next;
	logic [mmu_pkg::PPN_BITS-1:0] sel_ppn;
	logic [mmu_pkg::FLAG_BITS-1:0] sel_flags;

	// Odd page in the upper half
	assign sel_ppn = lookup_vaddr[mmu_pkg::PAGE_BITS]
		? rd_ppn[mmu_pkg::PPN_BITS +: mmu_pkg::PPN_BITS]
		: rd_ppn[0 +: mmu_pkg::PPN_BITS];
	assign sel_flags = lookup_vaddr[mmu_pkg::PAGE_BITS]
		? rd_flags[mmu_pkg::FLAG_BITS +: mmu_pkg::FLAG_BITS]
		: rd_flags[0 +: mmu_pkg::FLAG_BITS];

	// Request ends on a hit or a walker fault
	assign take_hit = rd_valid && rd_hit;
	assign done_next = take_hit || walk_fault;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			walked <= 1'b0;
			done <= 1'b0;
			paddr <= '0;
			flags <= '0;
			hit <= 1'b0;
			fault <= 1'b0;
		end else begin
			done <= done_next;
			fault <= walk_fault;
			hit <= take_hit && !walked;
			// PPN joined to the page offset
			paddr <= take_hit ? {sel_ppn, lookup_vaddr[mmu_pkg::PAGE_BITS-1:0]} : '0;
			flags <= take_hit ? sel_flags : '0;
			// Walk marker lives for one request
			if (done_next) begin
				walked <= 1'b0;
			end else if (retry) begin
				walked <= 1'b1;
			end
		end
	end

endmodule

//--- verilog/mmu_top.sv
// Translation unit top: request port, TLB, page walker, response
// req is a strobe, busy a level, done a one-cycle pulse
`timescale 1ns/1ns

module mmu_top (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic req,
	input  logic [mmu_pkg::VADDR_BITS-1:0] req_vaddr,
	output logic busy,
	input  logic flush,
	input  logic pt_wr,
	input  logic [mmu_pkg::PT_INDEX_BITS-1:0] pt_wr_index,
	input  logic [mmu_pkg::PPN_PAIR_BITS-1:0] pt_wr_ppn,
	input  logic [mmu_pkg::FLAG_PAIR_BITS-1:0] pt_wr_flags,
	output logic done,
	output logic [mmu_pkg::VADDR_BITS-1:0] paddr,
	output logic [mmu_pkg::FLAG_BITS-1:0] flags,
	output logic hit,
	output logic fault
);

	// Request side
	logic lookup;
	logic [mmu_pkg::VADDR_BITS-1:0] lookup_vaddr;
	logic retry;

	// TLB result
	logic rd_valid;
	logic rd_hit;
	logic [mmu_pkg::PPN_PAIR_BITS-1:0] rd_ppn;
	logic [mmu_pkg::FLAG_PAIR_BITS-1:0] rd_flags;

	// Refill path
	logic fill;
	logic [mmu_pkg::VADDR_BITS-1:0] fill_vaddr;
	logic [mmu_pkg::PPN_PAIR_BITS-1:0] fill_ppn;
	logic [mmu_pkg::FLAG_PAIR_BITS-1:0] fill_flags;
	logic walk_fault;

	mmu_request_port u_request (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .req(req), .req_vaddr(req_vaddr),
		.retry(retry), .done(done), .busy(busy), .lookup(lookup),
		.lookup_vaddr(lookup_vaddr)
	);

	mmu_tlb u_tlb (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .flush(flush), .lookup(lookup),
		.lookup_vaddr(lookup_vaddr), .fill(fill), .fill_vaddr(fill_vaddr),
		.fill_ppn(fill_ppn), .fill_flags(fill_flags), .rd_valid(rd_valid),
		.rd_hit(rd_hit), .rd_ppn(rd_ppn), .rd_flags(rd_flags)
	);

	mmu_page_walker u_walker (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .rd_valid(rd_valid), .rd_hit(rd_hit),
		.lookup_vaddr(lookup_vaddr), .pt_wr(pt_wr), .pt_wr_index(pt_wr_index),
		.pt_wr_ppn(pt_wr_ppn), .pt_wr_flags(pt_wr_flags), .fill(fill),
		.fill_vaddr(fill_vaddr), .fill_ppn(fill_ppn), .fill_flags(fill_flags),
		.retry(retry), .walk_fault(walk_fault)
	);

	mmu_response u_response (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .lookup_vaddr(lookup_vaddr),
		.rd_valid(rd_valid), .rd_hit(rd_hit), .rd_ppn(rd_ppn), .rd_flags(rd_flags),
		.walk_fault(walk_fault), .retry(retry), .done(done), .paddr(paddr),
		.flags(flags), .hit(hit), .fault(fault)
	);

endmodule

//--- test/mmu_top_asserts.sv
// Control checks bound into mmu_top by the testbench
// walk_state comes from the walker instance inside mmu_top
`timescale 1ns/1ns

module mmu_top_asserts (
	input logic iCLOCK,
	input logic inRESET,
	input logic busy,
	input logic done,
	input logic fault,
	input logic [mmu_pkg::VADDR_BITS-1:0] paddr,
	input logic fill,
	input logic flush,
	input mmu_pkg::walk_state_t walk_state
);

	// done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		done |=> !done)
		else $error("done held high for more than one cycle");

	// Faulted result carries no address
	a_fault_paddr: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		fault |-> paddr == '0)
		else $error("paddr nonzero with fault");

	// Flush wins over fill
	a_no_fill_on_flush: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(fill && flush))
		else $error("fill and flush in the same cycle");

	// A walk only runs inside an accepted request
	a_walk_while_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		walk_state != mmu_pkg::WALK_IDLE |-> busy)
		else $error("walker active while busy is low");

	a_idle_after_reset: assert property (@(posedge iCLOCK)
		$rose(inRESET) |-> !busy)
		else $error("busy high right after reset");

endmodule

//--- test/mmu_top_tb.sv
// Testbench for mmu_top driven line by line from test/mmu_stimulus.txt
// Run from the project root so the stimulus path resolves
// One request at a time; each T line waits for done before the next line
`timescale 1ns/1ns

module mmu_top_tb;

	logic iCLOCK;
	logic inRESET;
	logic req;
	logic [mmu_pkg::VADDR_BITS-1:0] req_vaddr;
	logic busy;
	logic flush;
	logic pt_wr;
	logic [mmu_pkg::PT_INDEX_BITS-1:0] pt_wr_index;
	logic [mmu_pkg::PPN_PAIR_BITS-1:0] pt_wr_ppn;
	logic [mmu_pkg::FLAG_PAIR_BITS-1:0] pt_wr_flags;
	logic done;
	logic [mmu_pkg::VADDR_BITS-1:0] paddr;
	logic [mmu_pkg::FLAG_BITS-1:0] flags;
	logic hit;
	logic fault;

	// Stimulus lines kept with their line numbers
	string stim_lines[$];
	int stim_line_no[$];
	int watchdog_cycles;
	int check_count;

	mmu_top uut (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .req(req), .req_vaddr(req_vaddr),
		.busy(busy), .flush(flush), .pt_wr(pt_wr), .pt_wr_index(pt_wr_index),
		.pt_wr_ppn(pt_wr_ppn), .pt_wr_flags(pt_wr_flags), .done(done),
		.paddr(paddr), .flags(flags), .hit(hit), .fault(fault)
	);

	// Control checks on the top level
	bind mmu_top mmu_top_asserts u_asserts (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .busy(busy), .done(done),
		.fault(fault), .paddr(paddr), .fill(fill), .flush(flush),
		.walk_state(u_walker.state)
	);

	// 4 ns clock
	always #2 iCLOCK = ~iCLOCK;

	task automatic check_value(input string test_name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			$display("FAILED %s %s: expected 0x%08h, actual 0x%08h",
				test_name, field, expected, actual);
			$display("Test failed");
			$fatal(1, "Result mismatch on %s", field);
		end
	endtask

	task automatic reject_line(input int line_no);
		$display("Stimulus line %0d could not be parsed", line_no);
		$display("Test failed");
		$fatal(1, "Bad stimulus line");
	endtask

	task automatic load_stimulus();
		int fd;
		int line_no;
		string line;
		fd = $fopen("test/mmu_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open test/mmu_stimulus.txt for reading");
			$display("Test failed");
			$fatal(1, "Missing stimulus file");
		end
		line_no = 0;
		while ($fgets(line, fd) != 0) begin
			line_no++;
			// Skip blank and comment lines
			if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n"
				&& line.getc(0) != "\r" && line.getc(0) != " ") begin
				stim_lines.push_back(line);
				stim_line_no.push_back(line_no);
			end
		end
		$fclose(fd);
	endtask

	// One-cycle table write
	task automatic write_table(input logic [63:0] index, input logic [63:0] ppn_pair,
		input logic [63:0] flag_pair);
		@(posedge iCLOCK);
		pt_wr <= 1'b1;
		pt_wr_index <= index[mmu_pkg::PT_INDEX_BITS-1:0];
		pt_wr_ppn <= ppn_pair[mmu_pkg::PPN_PAIR_BITS-1:0];
		pt_wr_flags <= flag_pair[mmu_pkg::FLAG_PAIR_BITS-1:0];
		@(posedge iCLOCK);
		pt_wr <= 1'b0;
	endtask

	task automatic flush_tlb();
		@(posedge iCLOCK);
		flush <= 1'b1;
		@(posedge iCLOCK);
		flush <= 1'b0;
	endtask

	// Request strobe, then results at the falling edge while done is high
	task automatic translate(input string test_name, input logic [31:0] vaddr,
		input logic [31:0] exp_paddr, input logic [31:0] exp_flags,
		input int exp_hit, input int exp_fault);
		@(posedge iCLOCK);
		req <= 1'b1;
		req_vaddr <= vaddr;
		@(posedge iCLOCK);
		req <= 1'b0;
		@(negedge iCLOCK);
		// Accepted request holds busy
		check_value(test_name, "busy", 32'd1, 32'(busy));
		while (!done) begin
			@(negedge iCLOCK);
		end
		check_value(test_name, "paddr", exp_paddr, paddr);
		check_value(test_name, "flags", exp_flags, 32'(flags));
		// Hit code 2 leaves hit unchecked
		if (exp_hit != 2) begin
			check_value(test_name, "hit", 32'(exp_hit), 32'(hit));
		end
		check_value(test_name, "fault", 32'(exp_fault), 32'(fault));
		// Next cycle the result is cleared and busy released
		@(negedge iCLOCK);
		check_value(test_name, "done after pulse", 32'd0, 32'(done));
		check_value(test_name, "busy after done", 32'd0, 32'(busy));
		check_value(test_name, "paddr after done", 32'd0, paddr);
		check_value(test_name, "flags after done", 32'd0, 32'(flags));
		check_value(test_name, "hit after done", 32'd0, 32'(hit));
		check_value(test_name, "fault after done", 32'd0, 32'(fault));
	endtask

	task automatic run_line(input string line, input int line_no);
		byte cmd;
		string rest;
		string test_name;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] c;
		int d;
		int e;
		int n;
		cmd = line.getc(0);
		rest = line.substr(1, line.len() - 1);
		case (cmd)
			"W": begin
				n = $sscanf(rest, "%h %h %h", a, b, c);
				if (n != 3) begin
					reject_line(line_no);
				end
				write_table(a, b, c);
			end
			"F": begin
				flush_tlb();
			end
			"T": begin
				n = $sscanf(rest, "%h %h %h %d %d", a, b, c, d, e);
				if (n != 5) begin
					reject_line(line_no);
				end
				test_name = $sformatf("line %0d T %08h", line_no, a[31:0]);
				translate(test_name, a[31:0], b[31:0], c[31:0], d, e);
			end
			default: begin
				reject_line(line_no);
			end
		endcase
	endtask

	// Watchdog allows 40 cycles per stimulus line
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge iCLOCK);
		$display("Watchdog expired after %0d cycles, the DUT stopped answering",
			watchdog_cycles);
		$display("Test failed");
		$fatal(1, "Watchdog timeout");
	end

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		req = 1'b0;
		req_vaddr = '0;
		flush = 1'b0;
		pt_wr = 1'b0;
		pt_wr_index = '0;
		pt_wr_ppn = '0;
		pt_wr_flags = '0;
		check_count = 0;
		watchdog_cycles = 0;
		load_stimulus();
		watchdog_cycles = (stim_lines.size() + 1) * 40;
		// Reset for 5 cycles
		repeat (5) @(posedge iCLOCK);
		inRESET <= 1'b1;
		foreach (stim_lines[i]) begin
			run_line(stim_lines[i], stim_line_no[i]);
		end
		repeat (2) @(posedge iCLOCK);
		if (check_count > 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("No result was checked, the stimulus holds no translation");
			$display("Test failed");
			$fatal(1, "Empty stimulus");
		end
	end

endmodule

//--- test/mmu_stimulus.txt
# W index ppn_pair flag_pair | F | T vaddr paddr flags hit fault  (hex, hit and fault decimal)
# Pairs hold the odd page in the upper half; hit 2 means hit is not checked
W 01 011580123 0084011
T 00020abc 0048cabc 0011 0 0
T 00020abc 0048cabc 0011 1 0
T 00024010 01158010 0021 1 0
T 00820000 00000000 0000 0 1
W 02 022200777 0004010
T 00040123 00000000 0000 0 1
T 000443ff 022203ff 0001 0 0
W 01 037bc0abc 001c005
T 00020abc 0048cabc 0011 1 0
F
T 00020abc 02af0abc 0005 0 0
T 00024010 037bc010 0007 1 0
W 03 0800c1003 000c041
W 04 080101004 000c041
W 05 080141005 000c041
W 06 080181006 000c041
W 07 0801c1007 000c041
T 00068300 0400c300 0041 0 0
T 00088400 04010400 0041 0 0
T 000a8500 04014500 0041 0 0
T 000c8600 04018600 0041 0 0
T 000e8700 0401c700 0041 0 0
T 00068300 0400c300 0041 2 0
T 00088400 04010400 0041 2 0
T 000a8500 04014500 0041 2 0
T 000c8600 04018600 0041 2 0
T 000e8700 0401c700 0041 2 0

//--- mmu_top.f
verilog/mmu_pkg.sv
verilog/mmu_request_port.sv
verilog/mmu_tlb.sv
verilog/mmu_page_walker.sv
verilog/mmu_response.sv
verilog/mmu_top.sv
test/mmu_top_asserts.sv
test/mmu_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the MMU testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mmu_top_tb -f mmu_top.f \
	--Mdir obj_dir -o mmu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/mmu_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qxF "Test completed successfully"; then
	exit 0
fi
exit 1
